// File: hdl/dma_pkg.sv
package dma_pkg;

    // transfer type doubles as the AXI burst encoding
    typedef enum logic [1:0] {
        TYPE_FIXED   = 2'd0,
        TYPE_INCR    = 2'd1,
        TYPE_CONST   = 2'd2,
        TYPE_UNKNOWN = 2'd3
    } dma_type_e;

    typedef enum logic [7:0] {
        REG_SRC  = 8'h00,
        REG_DEST = 8'h04,
        REG_LEN  = 8'h08,
        REG_CON  = 8'h0C,
        REG_IE   = 8'h10,
        REG_IP   = 8'h14,
        REG_IC   = 8'h18,
        REG_WDT  = 8'h1C
    } dma_reg_e;

    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;

    typedef enum logic [1:0] {WR_IDLE, WR_ADDR, WR_DATA, WR_RESP} wr_state_e;

    localparam int unsigned BURST_MAX = 4;
    localparam logic [30:0] WDT_RESET_VALUE = 31'h800;

    // beats of the next burst, an INCR burst stops at the 16-byte boundary
    function automatic logic [2:0] burst_beats(input logic [31:0] addr,
                                               input logic [29:0] words,
                                               input dma_type_e   kind);
        logic [2:0] room;
        room = (kind == TYPE_INCR) ? 3'(BURST_MAX) - {1'b0, addr[3:2]} : 3'(BURST_MAX);
        return (words < 30'(room)) ? words[2:0] : room;
    endfunction

endpackage

// File: hdl/dma_regs.sv
module dma_regs (
    input  logic               clk,
    input  logic               rstn,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [7:0]         paddr,
    input  logic [31:0]        pwdata,
    input  logic               done,
    input  logic               abort,
    input  logic               timeout_set,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               start,
    output logic [31:0]        src,
    output logic [31:0]        dest,
    output logic [29:0]        word_cnt,
    output dma_pkg::dma_type_e src_type,
    output dma_pkg::dma_type_e dest_type,
    output logic               busy,
    output logic [30:0]        wdt_reload,
    output logic               irq
);
    import dma_pkg::*;

    logic        apb_wr;
    logic        apb_rd;
    logic [31:0] len;
    logic        con_en;
    logic        ie;
    logic        ip;
    logic        timeout;
    logic        cfg_err;
    logic [31:0] rd_mux;

    // both directions act in the setup phase
    assign apb_wr   = psel && !penable && pwrite;
    assign apb_rd   = psel && !penable && !pwrite;
    assign pready   = 1'b1;
    assign word_cnt = len[31:2];
    assign irq      = ie && ip;

    // a constant source value needs no alignment
    assign cfg_err = (len == '0) || (len[1:0] != 2'b00) ||
                     (src_type == TYPE_UNKNOWN) ||
                     (dest_type == TYPE_UNKNOWN) || (dest_type == TYPE_CONST) ||
                     (src_type != TYPE_CONST && src[1:0] != 2'b00) ||
                     (dest[1:0] != 2'b00);

    assign start = con_en && !cfg_err;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            src        <= '0;
            dest       <= '0;
            len        <= '0;
            ie         <= 1'b0;
            wdt_reload <= WDT_RESET_VALUE;
        end else if (apb_wr) begin
            case (paddr)
                REG_SRC:  src <= pwdata;
                REG_DEST: dest <= pwdata;
                REG_LEN:  len <= pwdata;
                REG_IE:   ie <= pwdata[0];
                REG_WDT:  wdt_reload <= pwdata[30:0];
                default:  ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            con_en    <= 1'b0;
            busy      <= 1'b0;
            src_type  <= TYPE_FIXED;
            dest_type <= TYPE_FIXED;
        end else if (apb_wr && paddr == REG_CON && !busy) begin
            con_en    <= pwdata[0];
            busy      <= pwdata[0];
            src_type  <= dma_type_e'(pwdata[5:4]);
            dest_type <= dma_type_e'(pwdata[7:6]);
        end else begin
            con_en <= 1'b0;
            if ((con_en && cfg_err) || done || abort) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ip      <= 1'b0;
            timeout <= 1'b0;
        end else begin
            if (done) begin
                ip <= 1'b1;
            end else if (apb_wr && paddr == REG_IC && pwdata[0]) begin
                ip <= 1'b0;
            end
            // sticky until software writes bit 31 low
            if (timeout_set) begin
                timeout <= 1'b1;
            end else if (apb_wr && paddr == REG_WDT && !pwdata[31]) begin
                timeout <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_mux = '0;
        case (paddr)
            REG_SRC:  rd_mux = src;
            REG_DEST: rd_mux = dest;
            REG_LEN:  rd_mux = len;
            REG_CON:  rd_mux = {busy, 23'b0, dest_type, src_type, 3'b0, con_en};
            REG_IE:   rd_mux = {31'b0, ie};
            REG_IP:   rd_mux = {31'b0, ip};
            REG_WDT:  rd_mux = {timeout, wdt_reload};
            default:  rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (apb_rd) begin
            prdata <= rd_mux;
        end
    end

endmodule

// File: hdl/dma_fifo.sv
module dma_fifo #(
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     flush,
    input  logic                     push,
    input  logic [31:0]              push_data,
    input  logic                     pop,
    output logic [31:0]              pop_data,
    output logic [FIFO_DEPTH_LOG2:0] count,
    output logic                     full,
    output logic                     empty
);
    localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

    logic [31:0]                mem [DEPTH];
    logic [FIFO_DEPTH_LOG2-1:0] wptr;
    logic [FIFO_DEPTH_LOG2-1:0] rptr;

    assign full     = (count == DEPTH);
    assign empty    = (count == '0);
    // head word is visible before the pop
    assign pop_data = mem[rptr];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else if (flush) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wptr <= wptr + 1'b1;
            end
            if (pop) begin
                rptr <= rptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push && !flush) begin
            mem[wptr] <= push_data;
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rstn) push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rstn) pop |-> !empty);

endmodule

// File: hdl/dma_rd_engine.sv
module dma_rd_engine #(
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     start,
    input  logic                     abort,
    input  logic [31:0]              src,
    input  logic [29:0]              word_cnt,
    input  dma_pkg::dma_type_e       src_type,
    input  logic [FIFO_DEPTH_LOG2:0] fifo_count,
    input  logic                     fifo_full,
    output logic [31:0]              araddr,
    output logic [7:0]               arlen,
    output logic [1:0]               arburst,
    output logic                     arvalid,
    input  logic                     arready,
    input  logic [31:0]              rdata,
    input  logic                     rlast,
    input  logic                     rvalid,
    output logic                     rready,
    output logic                     push,
    output logic [31:0]              push_data
);
    import dma_pkg::*;

    localparam logic [FIFO_DEPTH_LOG2:0] FIFO_WORDS = 1 << FIFO_DEPTH_LOG2;

    rd_state_e                state;
    logic [31:0]              addr;
    logic [29:0]              words_left;
    logic [2:0]               beats;
    logic                     const_src;
    logic [FIFO_DEPTH_LOG2:0] space;

    assign const_src = (src_type == TYPE_CONST);
    assign beats     = burst_beats(addr, words_left, src_type);
    assign space     = FIFO_WORDS - fifo_count;

    assign araddr  = addr;
    assign arlen   = {5'b0, beats - 3'd1};
    assign arburst = src_type;
    // hold the address until the whole burst fits
    assign arvalid = (state == RD_ADDR) && (space >= {{(FIFO_DEPTH_LOG2 - 2){1'b0}}, beats});
    assign rready  = !fifo_full;

    assign push      = (state == RD_DATA) && (const_src ? !fifo_full : rvalid && rready);
    assign push_data = const_src ? src : rdata;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= RD_IDLE;
            addr       <= '0;
            words_left <= '0;
        end else if (abort) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: if (start) begin
                    addr       <= src;
                    words_left <= word_cnt;
                    state      <= const_src ? RD_DATA : RD_ADDR;
                end
                RD_ADDR: if (arvalid && arready) begin
                    words_left <= words_left - {27'b0, beats};
                    if (src_type == TYPE_INCR) begin
                        addr <= addr + {27'b0, beats, 2'b00};
                    end
                    state <= RD_DATA;
                end
                RD_DATA: if (const_src) begin
                    // constant fill counts per pushed word
                    if (push) begin
                        words_left <= words_left - 30'd1;
                        if (words_left == 30'd1) begin
                            state <= RD_IDLE;
                        end
                    end
                end else if (push && rlast) begin
                    state <= (words_left == '0) ? RD_IDLE : RD_ADDR;
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    a_ar_stable: assert property (@(posedge clk) disable iff (!rstn || abort)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen));

endmodule

// File: hdl/dma_wr_engine.sv
module dma_wr_engine #(
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     start,
    input  logic                     abort,
    input  logic [31:0]              dest,
    input  logic [29:0]              word_cnt,
    input  dma_pkg::dma_type_e       dest_type,
    input  logic [FIFO_DEPTH_LOG2:0] fifo_count,
    input  logic [31:0]              pop_data,
    output logic [31:0]              awaddr,
    output logic [7:0]               awlen,
    output logic [1:0]               awburst,
    output logic                     awvalid,
    input  logic                     awready,
    output logic [31:0]              wdata,
    output logic [3:0]               wstrb,
    output logic                     wlast,
    output logic                     wvalid,
    input  logic                     wready,
    input  logic                     bvalid,
    output logic                     bready,
    output logic                     pop,
    output logic                     done
);
    import dma_pkg::*;

    wr_state_e   state;
    logic [31:0] addr;
    logic [29:0] words_left;
    logic [2:0]  beats;
    logic [2:0]  beat_cnt;

    assign beats = burst_beats(addr, words_left, dest_type);

    assign awaddr  = addr;
    assign awlen   = {5'b0, beats - 3'd1};
    assign awburst = dest_type;
    // only start a burst the FIFO can cover completely
    assign awvalid = (state == WR_ADDR) &&
                     (fifo_count >= {{(FIFO_DEPTH_LOG2 - 2){1'b0}}, beats});

    assign wdata  = pop_data;
    assign wstrb  = 4'hF;
    assign wvalid = (state == WR_DATA);
    assign wlast  = (beat_cnt == 3'd0);
    assign bready = 1'b1;
    assign pop    = wvalid && wready;
    assign done   = (state == WR_RESP) && bvalid && (words_left == '0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= WR_IDLE;
            addr       <= '0;
            words_left <= '0;
            beat_cnt   <= '0;
        end else if (abort) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: if (start) begin
                    addr       <= dest;
                    words_left <= word_cnt;
                    state      <= WR_ADDR;
                end
                WR_ADDR: if (awvalid && awready) begin
                    words_left <= words_left - {27'b0, beats};
                    beat_cnt   <= beats - 3'd1;
                    if (dest_type == TYPE_INCR) begin
                        addr <= addr + {27'b0, beats, 2'b00};
                    end
                    state <= WR_DATA;
                end
                WR_DATA: if (pop) begin
                    if (wlast) begin
                        state <= WR_RESP;
                    end else begin
                        beat_cnt <= beat_cnt - 3'd1;
                    end
                end
                WR_RESP: if (bvalid) begin
                    state <= (words_left == '0) ? WR_IDLE : WR_ADDR;
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    a_aw_stable: assert property (@(posedge clk) disable iff (!rstn || abort)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen));
    a_w_stable: assert property (@(posedge clk) disable iff (!rstn || abort)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast));

endmodule

// File: hdl/dma_wdt.sv
module dma_wdt (
    input  logic        clk,
    input  logic        rstn,
    input  logic        busy,
    input  logic        start,
    input  logic        push,
    input  logic        pop,
    input  logic [30:0] wdt_reload,
    output logic        abort,
    output logic        timeout_set
);
    import dma_pkg::*;

    logic [30:0] cnt;
    logic        expired;

    assign expired     = busy && (cnt == '0);
    assign timeout_set = expired;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt   <= WDT_RESET_VALUE;
            abort <= 1'b0;
        end else begin
            abort <= expired;
            // any FIFO traffic counts as progress
            if (start || push || pop || expired) begin
                cnt <= wdt_reload;
            end else if (busy) begin
                cnt <= cnt - 31'd1;
            end
        end
    end

endmodule

// File: hdl/dma_top.sv
module dma_top #(
    parameter int FIFO_DEPTH_LOG2 = 4
) (
    input  logic        clk,
    input  logic        rstn,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic [31:0] araddr,
    output logic [7:0]  arlen,
    output logic [1:0]  arburst,
    output logic        arvalid,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  logic        rlast,
    input  logic        rvalid,
    output logic        rready,
    output logic [31:0] awaddr,
    output logic [7:0]  awlen,
    output logic [1:0]  awburst,
    output logic        awvalid,
    input  logic        awready,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb,
    output logic        wlast,
    output logic        wvalid,
    input  logic        wready,
    input  logic        bvalid,
    output logic        bready,
    output logic        irq
);
    import dma_pkg::*;

    logic                     start;
    logic [31:0]              src;
    logic [31:0]              dest;
    logic [29:0]              word_cnt;
    dma_type_e                src_type;
    dma_type_e                dest_type;
    logic                     busy;
    logic [30:0]              wdt_reload;
    logic                     done;
    logic                     abort;
    logic                     timeout_set;
    logic                     push;
    logic [31:0]              push_data;
    logic                     pop;
    logic [31:0]              pop_data;
    logic [FIFO_DEPTH_LOG2:0] count;
    logic                     full;

    dma_regs u_regs (.*);

    dma_fifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_fifo (
        .*,
        .flush (abort),
        .empty ()
    );

    dma_rd_engine #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_rd (
        .*,
        .fifo_count (count),
        .fifo_full  (full)
    );

    dma_wr_engine #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_wr (
        .*,
        .fifo_count (count)
    );

    dma_wdt u_wdt (.*);

endmodule

// File: tests/axi_mem.sv
module axi_mem (
    input  logic        clk,
    input  logic        rstn,
    input  logic        aw_stall,
    input  logic        load,
    input  logic [9:0]  load_addr,
    input  logic [31:0] load_data,
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    input  logic [1:0]  arburst,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready,
    input  logic [31:0] awaddr,
    input  logic [7:0]  awlen,
    input  logic [1:0]  awburst,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wlast,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [1024];
    logic        rd_busy;
    logic [9:0]  rd_idx;
    logic [7:0]  rd_left;
    logic        rd_incr;
    logic        wr_busy;
    logic [9:0]  wr_idx;
    logic        wr_incr;

    assign arready = !rd_busy;
    assign rvalid  = rd_busy;
    assign rdata   = mem[rd_idx];
    assign rlast   = (rd_left == 8'd0);
    // one write burst at a time, including its response
    assign awready = !wr_busy && !bvalid && !aw_stall;
    assign wready  = wr_busy;

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_busy <= 1'b0;
            rd_idx  <= '0;
            rd_left <= '0;
            rd_incr <= 1'b0;
            wr_busy <= 1'b0;
            wr_idx  <= '0;
            wr_incr <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                rd_busy <= 1'b1;
                rd_idx  <= araddr[11:2];
                rd_left <= arlen;
                rd_incr <= (arburst == 2'd1);
            end else if (rvalid && rready) begin
                if (rlast) begin
                    rd_busy <= 1'b0;
                end else begin
                    rd_left <= rd_left - 8'd1;
                    rd_idx  <= rd_incr ? rd_idx + 10'd1 : rd_idx;
                end
            end
            if (awvalid && awready) begin
                wr_busy <= 1'b1;
                wr_idx  <= awaddr[11:2];
                wr_incr <= (awburst == 2'd1);
            end else if (wvalid && wready) begin
                wr_idx <= wr_incr ? wr_idx + 10'd1 : wr_idx;
                if (wlast) begin
                    wr_busy <= 1'b0;
                    bvalid  <= 1'b1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (load) begin
            mem[load_addr] <= load_data;
        end else if (wvalid && wready) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: tests/dma_tb.sv
module dma_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dma_pkg::*;

    typedef enum logic [1:0] {OUT_DONE, OUT_ERROR, OUT_TIMEOUT} outcome_e;

    typedef struct packed {
        logic [31:0] src;
        logic [31:0] dest;
        logic [31:0] len;
        dma_type_e   src_type;
        dma_type_e   dest_type;
        logic        ie;
        logic        stall;
        outcome_e    outcome;
    } row_t;

    localparam int NUM_ROWS  = 13;
    localparam int MEM_WORDS = 1024;

    logic        clk;
    logic        rstn;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic [31:0] araddr;
    logic [7:0]  arlen;
    logic [1:0]  arburst;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rlast;
    logic        rvalid;
    logic        rready;
    logic [31:0] awaddr;
    logic [7:0]  awlen;
    logic [1:0]  awburst;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wlast;
    logic        wvalid;
    logic        wready;
    logic        bvalid;
    logic        bready;
    logic        irq;
    logic        aw_stall;
    logic        load;
    logic [9:0]  load_addr;
    logic [31:0] load_data;

    row_t        rows [NUM_ROWS];
    logic [31:0] expected [MEM_WORDS];
    int          errors = 0;
    int          failed_tests = 0;
    int          tests_run = 0;
    int          cycles = 0;
    int          cycle_limit = 100000;
    int          valid_cnt = 0;
    int          beats_seen = 0;
    logic [7:0]  len_seen = '0;

    dma_top dma_top_i (.*);
    axi_mem mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (arvalid || awvalid || wvalid) begin
            valid_cnt <= valid_cnt + 1;
        end
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not end within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    // write bursts stay inside a 16-byte block and match their length
    always @(posedge clk) begin
        if (awvalid && awready) begin
            if (awburst == 2'd1 && ({6'b0, awaddr[3:2]} + awlen) > 8'd3) begin
                report_mismatch("awlen past 16-byte boundary", {24'b0, awlen},
                                {30'b0, 2'd3 - awaddr[3:2]});
            end
            len_seen   <= awlen;
            beats_seen <= 0;
        end else if (wvalid && wready) begin
            if (wlast && beats_seen != int'(len_seen)) begin
                report_mismatch("W beats before wlast", beats_seen, {24'b0, len_seen});
            end
            beats_seen <= beats_seen + 1;
        end
    end

    task automatic load_table();
        // src, dest, len, src type, dest type, ie, stall, outcome
        rows[0]  = '{32'h100, 32'h400, 32'd4, TYPE_INCR, TYPE_INCR, 1'b1, 1'b0, OUT_DONE};
        rows[1]  = '{32'h108, 32'h424, 32'd20, TYPE_INCR, TYPE_INCR, 1'b0, 1'b0, OUT_DONE};
        rows[2]  = '{32'h140, 32'h480, 32'd64, TYPE_INCR, TYPE_INCR, 1'b1, 1'b0, OUT_DONE};
        rows[3]  = '{32'h134, 32'h50C, 32'd64, TYPE_INCR, TYPE_INCR, 1'b0, 1'b0, OUT_DONE};
        // constant fill, src alignment does not matter
        rows[4]  = '{32'hA5A5_0003, 32'h600, 32'd28, TYPE_CONST, TYPE_INCR, 1'b1, 1'b0, OUT_DONE};
        rows[5]  = '{32'h200, 32'h700, 32'd24, TYPE_INCR, TYPE_FIXED, 1'b0, 1'b0, OUT_DONE};
        rows[6]  = '{32'h100, 32'h400, 32'd0, TYPE_INCR, TYPE_INCR, 1'b1, 1'b0, OUT_ERROR};
        rows[7]  = '{32'h100, 32'h400, 32'd6, TYPE_INCR, TYPE_INCR, 1'b1, 1'b0, OUT_ERROR};
        rows[8]  = '{32'h100, 32'h402, 32'd8, TYPE_INCR, TYPE_INCR, 1'b0, 1'b0, OUT_ERROR};
        rows[9]  = '{32'h100, 32'h400, 32'd8, TYPE_INCR, TYPE_UNKNOWN, 1'b0, 1'b0, OUT_ERROR};
        rows[10] = '{32'h100, 32'h400, 32'd8, TYPE_INCR, TYPE_CONST, 1'b0, 1'b0, OUT_ERROR};
        rows[11] = '{32'h300, 32'h800, 32'd32, TYPE_INCR, TYPE_INCR, 1'b0, 1'b1, OUT_TIMEOUT};
        rows[12] = '{32'h320, 32'h880, 32'd40, TYPE_INCR, TYPE_INCR, 1'b1, 1'b0, OUT_DONE};
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        if (pready !== 1'b1) begin
            report_mismatch("pready in write access", {31'b0, pready}, 32'h1);
        end
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        if (pready !== 1'b1) begin
            report_mismatch("pready in read access", {31'b0, pready}, 32'h1);
        end
        data    = prdata;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
        errors++;
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d (%s): pass", num, name);
        end else begin
            $display("test %0d (%s): FAIL with %0d errors", num, name, errors - err_before);
            failed_tests++;
        end
    endtask

    task automatic preload_memory();
        logic [31:0] word;
        for (int k = 0; k < MEM_WORDS; k++) begin
            word = $urandom;
            @(negedge clk);
            load        = 1'b1;
            load_addr   = 10'(k);
            load_data   = word;
            expected[k] = word;
        end
        @(negedge clk);
        load = 1'b0;
    endtask

    task automatic wait_irq();
        int n;
        n = 0;
        while (!irq && n < 400) begin
            @(negedge clk);
            n++;
        end
        if (!irq) begin
            $display("at %0t ns: irq did not rise within %0d cycles", $time, n);
            errors++;
        end
    endtask

    task automatic wait_not_busy();
        logic [31:0] con;
        int          polls;
        polls = 0;
        apb_read(REG_CON, con);
        while (con[31] && polls < 100) begin
            apb_read(REG_CON, con);
            polls++;
        end
        if (con[31]) begin
            $display("at %0t ns: transfer still busy after %0d polls of CON", $time, polls);
            errors++;
        end
    endtask

    task automatic update_expected(input row_t r);
        int          n;
        int          s;
        int          d;
        logic [31:0] word;
        n = int'(r.len >> 2);
        s = int'(r.src[11:2]);
        d = int'(r.dest[11:2]);
        for (int i = 0; i < n; i++) begin
            // a fixed side keeps its address on every beat
            if (r.src_type == TYPE_CONST) begin
                word = r.src;
            end else begin
                word = expected[(r.src_type == TYPE_INCR) ? s + i : s];
            end
            expected[(r.dest_type == TYPE_INCR) ? d + i : d] = word;
        end
    endtask

    task automatic check_memory();
        for (int k = 0; k < MEM_WORDS; k++) begin
            if (mem_i.mem[k] !== expected[k]) begin
                report_mismatch($sformatf("mem[0x%0h]", k * 4), mem_i.mem[k], expected[k]);
            end
        end
    endtask

    task automatic run_row(input int num, input row_t r);
        logic [31:0] rd;
        int          err_before;
        int          valid_before;
        err_before = errors;
        if (r.stall) begin
            apb_write(REG_WDT, 32'd20);
        end
        apb_write(REG_SRC, r.src);
        apb_write(REG_DEST, r.dest);
        apb_write(REG_LEN, r.len);
        apb_write(REG_IE, {31'b0, r.ie});
        aw_stall     = r.stall;
        valid_before = valid_cnt;
        apb_write(REG_CON, {24'b0, r.dest_type, r.src_type, 3'b0, 1'b1});
        if (r.outcome == OUT_ERROR) begin
            apb_read(REG_CON, rd);
            if (rd[31] !== 1'b0) begin
                report_mismatch("CON busy after rejected start", {31'b0, rd[31]}, 32'h0);
            end
        end else begin
            if (r.ie && r.outcome == OUT_DONE) begin
                wait_irq();
            end
            wait_not_busy();
        end
        aw_stall = 1'b0;
        apb_read(REG_IP, rd);
        case (r.outcome)
            OUT_DONE: begin
                update_expected(r);
                if (rd !== 32'h1) begin
                    report_mismatch("IP after done", rd, 32'h1);
                end
                if (irq !== r.ie) begin
                    report_mismatch("irq after done", {31'b0, irq}, {31'b0, r.ie});
                end
                apb_write(REG_IC, 32'h1);
                if (irq !== 1'b0) begin
                    report_mismatch("irq after IC write", {31'b0, irq}, 32'h0);
                end
                apb_read(REG_IP, rd);
                if (rd !== 32'h0) begin
                    report_mismatch("IP after IC write", rd, 32'h0);
                end
            end
            OUT_ERROR: begin
                if (rd !== 32'h0) begin
                    report_mismatch("IP after rejected start", rd, 32'h0);
                end
                if (valid_cnt != valid_before) begin
                    $display("at %0t ns: AXI valid raised for a rejected setup", $time);
                    errors++;
                end
            end
            default: begin
                if (rd !== 32'h0) begin
                    report_mismatch("IP after watchdog abort", rd, 32'h0);
                end
                apb_read(REG_WDT, rd);
                if (rd !== 32'h8000_0014) begin
                    report_mismatch("WDT after watchdog abort", rd, 32'h8000_0014);
                end
                apb_write(REG_WDT, {1'b0, WDT_RESET_VALUE});
                apb_read(REG_WDT, rd);
                if (rd !== 32'h0000_0800) begin
                    report_mismatch("WDT after flag clear", rd, 32'h0000_0800);
                end
            end
        endcase
        check_memory();
        report_test(num, $sformatf("src %h dest %h len %0d", r.src, r.dest, r.len), err_before);
    endtask

    initial begin
        logic [31:0] rd;
        int          words;
        int          err_before;
        void'($urandom(32'hd657));
        rstn      = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        aw_stall  = 1'b0;
        load      = 1'b0;
        load_addr = '0;
        load_data = '0;
        load_table();
        words = 0;
        foreach (rows[i]) begin
            words += int'(rows[i].len >> 2);
        end
        // preload plus a per-row allowance for register traffic
        cycle_limit = MEM_WORDS + 200 * NUM_ROWS + 4 * words;
        repeat (2) @(negedge clk);
        rstn = 1'b1;
        preload_memory();

        err_before = errors;
        apb_read(REG_CON, rd);
        if (rd !== 32'h0) begin
            report_mismatch("CON after reset", rd, 32'h0);
        end
        apb_read(REG_IE, rd);
        if (rd !== 32'h0) begin
            report_mismatch("IE after reset", rd, 32'h0);
        end
        apb_read(REG_WDT, rd);
        if (rd !== 32'h0000_0800) begin
            report_mismatch("WDT after reset", rd, 32'h0000_0800);
        end
        apb_write(REG_SRC, 32'h1234_5678);
        apb_read(REG_SRC, rd);
        if (rd !== 32'h1234_5678) begin
            report_mismatch("SRC read-back", rd, 32'h1234_5678);
        end
        apb_write(REG_DEST, 32'h0000_0ABC);
        apb_read(REG_DEST, rd);
        if (rd !== 32'h0000_0ABC) begin
            report_mismatch("DEST read-back", rd, 32'h0000_0ABC);
        end
        apb_write(REG_LEN, 32'h0000_0100);
        apb_read(REG_LEN, rd);
        if (rd !== 32'h0000_0100) begin
            report_mismatch("LEN read-back", rd, 32'h0000_0100);
        end
        report_test(0, "reset values and read-back", err_before);

        for (int t = 0; t < NUM_ROWS; t++) begin
            run_row(t + 1, rows[t]);
        end

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, failed_tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: build.f
hdl/dma_pkg.sv
hdl/dma_regs.sv
hdl/dma_fifo.sv
hdl/dma_rd_engine.sv
hdl/dma_wr_engine.sv
hdl/dma_wdt.sv
hdl/dma_top.sv
tests/axi_mem.sv
tests/dma_tb.sv

// File: Makefile
SIM  := obj_dir/dma_tb
SRCS := $(shell cat build.f)

.PHONY: run clean

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -qx "No errors" sim.log

$(SIM): build.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module dma_tb -o dma_tb

clean:
	rm -rf obj_dir sim.log
